//--- mac_settings.svh
`ifndef MAC_SETTINGS_SVH
`define MAC_SETTINGS_SVH

// Client data width
// Also the write mask width and the memory word width
`define MAC_DATA_W 32

// Number of memory words
// Must be a power of two, the next-word address wraps on it
`define MAC_MEM_WORDS 1024

// Cycles from an accepted read command to its valid pulse
// At least 1
`define MAC_MEM_LATENCY 2

// All-ones mask, an aligned write with this mask needs no read first
`define MAC_FULL_MASK {`MAC_DATA_W{1'b1}}

`endif

//--- access_pkg.sv
`include "mac_settings.svh"

package access_pkg;

    // Byte position inside a word
    typedef logic [1:0] byte_offset_t;

    // Word index and byte offset view of a byte address
    typedef struct packed {
        logic [29:0]  word;
        byte_offset_t offset;
    } addr_fields_s;

    // One address word, decoded either as a plain byte address or split
    typedef union packed {
        logic [31:0]  raw;
        addr_fields_s fields;
    } byte_addr_u;

    // Client request as it arrives at the port
    typedef struct packed {
        logic                   write;
        byte_addr_u             addr;
        logic [`MAC_DATA_W-1:0] wdata;
        // Bit mask, set bits are written
        logic [`MAC_DATA_W-1:0] wmask;
    } access_req_s;

    // How an access maps onto word commands
    typedef enum logic [2:0] {
        kind_read_aligned = 3'd0,
        kind_read_split   = 3'd1,
        kind_write_full   = 3'd2,
        kind_write_rmw    = 3'd3,
        kind_write_split  = 3'd4
    } access_kind_e;

endpackage

//--- mem_pkg.sv
`include "mac_settings.svh"

package mem_pkg;

    // Word index on the memory side
    // Memory uses only the low bits it needs
    typedef logic [29:0] word_addr_t;

    // One word command
    // wdata is ignored for reads
    typedef struct packed {
        logic                   write;
        word_addr_t             addr;
        logic [`MAC_DATA_W-1:0] wdata;
    } word_cmd_s;

endpackage

//--- access_decode.sv
`include "mac_settings.svh"

module access_decode (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     accept,
    input  access_pkg::access_req_s  req,
    output access_pkg::access_kind_e kind,
    output mem_pkg::word_addr_t      first_word,
    output mem_pkg::word_addr_t      next_word,
    output access_pkg::byte_offset_t offset,
    output logic [`MAC_DATA_W-1:0]   wdata,
    output logic [`MAC_DATA_W-1:0]   wmask
);
    import access_pkg::*;
    import mem_pkg::*;

    // Keeps word indices inside the memory
    localparam word_addr_t WORD_MASK = word_addr_t'(`MAC_MEM_WORDS - 1);

    access_req_s req_q;
    byte_addr_u  next_addr;

    // Request held for the whole access
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req_q <= '0;
        end else if (accept) begin
            req_q <= req;
        end
    end

    // Byte address of the following word, as a plain sum
    assign next_addr.raw = req_q.addr.raw + 32'd4;

    // Struct view gives index and lane
    assign first_word = req_q.addr.fields.word & WORD_MASK;
    assign next_word  = next_addr.fields.word & WORD_MASK;
    assign offset     = req_q.addr.fields.offset;
    assign wdata      = req_q.wdata;
    assign wmask      = req_q.wmask;

    // One kind per access, everything downstream keys off it
    always_comb begin
        if (!req_q.write) begin
            kind = (offset == 2'd0) ? kind_read_aligned : kind_read_split;
        end else if (offset != 2'd0) begin
            kind = kind_write_split;
        end else if (req_q.wmask == `MAC_FULL_MASK) begin
            kind = kind_write_full;
        end else begin
            // Partial mask, old bits must come from memory
            kind = kind_write_rmw;
        end
    end

endmodule

//--- access_sequencer.sv
`include "mac_settings.svh"

module access_sequencer (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     req_start,
    input  access_pkg::access_kind_e kind,
    input  mem_pkg::word_addr_t      first_word,
    input  mem_pkg::word_addr_t      next_word,
    input  logic                     mem_ready,
    input  logic [`MAC_DATA_W-1:0]   mem_rdata,
    input  logic                     mem_rdata_valid,
    input  logic [`MAC_DATA_W-1:0]   merged_low,
    input  logic [`MAC_DATA_W-1:0]   merged_high,
    output logic                     cmd_ready,
    output logic                     accept,
    output logic                     mem_start,
    output mem_pkg::word_cmd_s       mem_cmd,
    output logic [`MAC_DATA_W-1:0]   first_rdata,
    output logic [`MAC_DATA_W-1:0]   second_rdata,
    output logic                     rdata_valid
);
    import access_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_wait_rd1,
        st_wait_rd2,
        st_write_low,
        st_write_high,
        st_done
    } state_e;

    state_e state;
    // Read of the current state already taken by the memory
    logic   rd_issued;
    logic   mem_accept;
    logic   rd_arrived;
    logic   first_is_write;

    assign cmd_ready  = (state == st_idle);
    assign accept     = req_start && cmd_ready;
    assign mem_accept = mem_start && mem_ready;
    assign rd_arrived = rd_issued && mem_rdata_valid;

    // A full write needs no read and goes out from the first state
    assign first_is_write = (kind == kind_write_full);

    // Command for the current state
    // Memory is always idle when a command is due
    always_comb begin
        mem_start = 1'b0;
        mem_cmd   = '{write: 1'b0, addr: first_word, wdata: '0};
        case (state)
            st_wait_rd1: begin
                mem_start = !rd_issued;
                if (first_is_write) begin
                    mem_cmd.write = 1'b1;
                    mem_cmd.wdata = merged_low;
                end
            end
            st_wait_rd2: begin
                mem_start    = !rd_issued;
                mem_cmd.addr = next_word;
            end
            st_write_low: begin
                mem_start     = 1'b1;
                mem_cmd.write = 1'b1;
                mem_cmd.wdata = merged_low;
            end
            st_write_high: begin
                mem_start     = 1'b1;
                mem_cmd.write = 1'b1;
                mem_cmd.addr  = next_word;
                mem_cmd.wdata = merged_high;
            end
            default: begin
                mem_start = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= st_idle;
            rd_issued <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (accept) begin
                        state <= st_wait_rd1;
                    end
                end
                st_wait_rd1: begin
                    if (first_is_write) begin
                        if (mem_accept) begin
                            state <= st_done;
                        end
                    end else begin
                        if (mem_accept) begin
                            rd_issued <= 1'b1;
                        end
                        if (rd_arrived) begin
                            rd_issued <= 1'b0;
                            case (kind)
                                kind_read_aligned: state <= st_done;
                                kind_write_rmw:    state <= st_write_low;
                                default:           state <= st_wait_rd2;
                            endcase
                        end
                    end
                end
                st_wait_rd2: begin
                    if (mem_accept) begin
                        rd_issued <= 1'b1;
                    end
                    if (rd_arrived) begin
                        rd_issued <= 1'b0;
                        // A split read ends here while a split write goes on to write back
                        state <= (kind == kind_read_split) ? st_done : st_write_low;
                    end
                end
                st_write_low: begin
                    if (mem_accept) begin
                        state <= (kind == kind_write_split) ? st_write_high : st_done;
                    end
                end
                st_write_high: begin
                    if (mem_accept) begin
                        state <= st_done;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // Read words kept for the merge
    always_ff @(posedge clk) begin
        if (rd_arrived && state == st_wait_rd1) begin
            first_rdata <= mem_rdata;
        end
        if (rd_arrived && state == st_wait_rd2) begin
            second_rdata <= mem_rdata;
        end
    end

    // Client pulse on the last word of a read
    assign rdata_valid = rd_arrived &&
        ((state == st_wait_rd1 && kind == kind_read_aligned) ||
         (state == st_wait_rd2 && kind == kind_read_split));

    // Every memory valid belongs to a read issued here
    valid_has_read: assert property (@(posedge clk) disable iff (!rst_n)
        mem_rdata_valid |-> rd_issued && (state inside {st_wait_rd1, st_wait_rd2}));

    // FSM only asks for the memory when it is free
    start_when_ready: assert property (@(posedge clk) disable iff (!rst_n)
        !mem_ready |-> !mem_start);

endmodule

//--- lane_merge.sv
`include "mac_settings.svh"

module lane_merge (
    input  access_pkg::byte_offset_t offset,
    input  logic [`MAC_DATA_W-1:0]   wdata,
    input  logic [`MAC_DATA_W-1:0]   wmask,
    input  logic [`MAC_DATA_W-1:0]   first_rdata,
    input  logic [`MAC_DATA_W-1:0]   second_rdata,
    input  logic [`MAC_DATA_W-1:0]   mem_rdata,
    output logic [`MAC_DATA_W-1:0]   rdata,
    output logic [`MAC_DATA_W-1:0]   merged_low,
    output logic [`MAC_DATA_W-1:0]   merged_high
);
    localparam int W = `MAC_DATA_W;

    // Bit shift for the byte offset
    logic [4:0]     shift;
    // Write data and mask spread over low word and high word
    logic [2*W-1:0] data_lanes;
    logic [2*W-1:0] mask_lanes;
    // Arriving word above the first word, shifted down
    logic [2*W-1:0] read_pair;

    // Old bits where the mask is clear, new bits where it is set
    function automatic logic [W-1:0] merge_word(
        input logic [W-1:0] old_word,
        input logic [W-1:0] new_word,
        input logic [W-1:0] mask
    );
        return (old_word & ~mask) | (new_word & mask);
    endfunction

    assign shift = {offset, 3'b000};

    // Little-endian, byte n of the access lands at byte offset+n
    assign data_lanes = {{W{1'b0}}, wdata} << shift;
    assign mask_lanes = {{W{1'b0}}, wmask} << shift;

    // Upper bytes of the first word, then lower bytes of the second
    assign read_pair = {mem_rdata, first_rdata} >> shift;

    // Aligned read is the arriving word itself
    assign rdata = (offset == 2'd0) ? mem_rdata : read_pair[W-1:0];

    // Low word, also the plain read-modify-write result
    assign merged_low  = merge_word(first_rdata, data_lanes[W-1:0], mask_lanes[W-1:0]);
    // High word, only written for split writes
    assign merged_high = merge_word(second_rdata, data_lanes[2*W-1:W], mask_lanes[2*W-1:W]);

endmodule

//--- word_memory.sv
`include "mac_settings.svh"

module word_memory (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   mem_start,
    input  mem_pkg::word_cmd_s     mem_cmd,
    output logic                   mem_ready,
    output logic [`MAC_DATA_W-1:0] mem_rdata,
    output logic                   mem_rdata_valid
);
    localparam int IDX_W = $clog2(`MAC_MEM_WORDS);
    localparam int CNT_W = $clog2(`MAC_MEM_LATENCY + 1);

    logic [`MAC_DATA_W-1:0] store [`MAC_MEM_WORDS];
    logic [IDX_W-1:0]       idx;
    // Cycles left on the outstanding read, zero when none
    logic [CNT_W-1:0]       lat_cnt;
    logic                   busy;
    logic                   cmd_accept;

    // Upper index bits are ignored
    assign idx = mem_cmd.addr[IDX_W-1:0];

    // Ready comes back in the valid cycle
    assign busy            = (lat_cnt > CNT_W'(1));
    assign mem_ready       = !busy;
    assign mem_rdata_valid = (lat_cnt == CNT_W'(1));
    assign cmd_accept      = mem_start && mem_ready;

    // Write lands at the accepting edge
    // Read word is taken at once and held until its valid pulse
    always_ff @(posedge clk) begin
        if (cmd_accept) begin
            if (mem_cmd.write) begin
                store[idx] <= mem_cmd.wdata;
            end else begin
                mem_rdata <= store[idx];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lat_cnt <= '0;
        end else if (cmd_accept && !mem_cmd.write) begin
            lat_cnt <= CNT_W'(`MAC_MEM_LATENCY);
        end else if (lat_cnt != '0) begin
            lat_cnt <= lat_cnt - CNT_W'(1);
        end
    end

    // One read at a time, no new read on top of a counting one
    single_read: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_start && !mem_cmd.write) |-> !busy);

endmodule

//--- mem_access_ctrl.sv
`include "mac_settings.svh"

module mem_access_ctrl (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    req_start,
    input  access_pkg::access_req_s req,
    output logic                    cmd_ready,
    output logic [`MAC_DATA_W-1:0]  rdata,
    output logic                    rdata_valid
);
    import access_pkg::*;
    import mem_pkg::*;

    // Decode to sequencer and merge
    logic                   accept;
    access_kind_e           kind;
    word_addr_t             first_word;
    word_addr_t             next_word;
    byte_offset_t           offset;
    logic [`MAC_DATA_W-1:0] wdata;
    logic [`MAC_DATA_W-1:0] wmask;

    // Sequencer and merge
    logic [`MAC_DATA_W-1:0] first_rdata;
    logic [`MAC_DATA_W-1:0] second_rdata;
    logic [`MAC_DATA_W-1:0] merged_low;
    logic [`MAC_DATA_W-1:0] merged_high;

    // Memory port
    logic                   mem_start;
    word_cmd_s              mem_cmd;
    logic                   mem_ready;
    logic [`MAC_DATA_W-1:0] mem_rdata;
    logic                   mem_rdata_valid;

    access_decode u_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .accept     (accept),
        .req        (req),
        .kind       (kind),
        .first_word (first_word),
        .next_word  (next_word),
        .offset     (offset),
        .wdata      (wdata),
        .wmask      (wmask)
    );

    access_sequencer u_sequencer (
        .clk             (clk),
        .rst_n           (rst_n),
        .req_start       (req_start),
        .kind            (kind),
        .first_word      (first_word),
        .next_word       (next_word),
        .mem_ready       (mem_ready),
        .mem_rdata       (mem_rdata),
        .mem_rdata_valid (mem_rdata_valid),
        .merged_low      (merged_low),
        .merged_high     (merged_high),
        .cmd_ready       (cmd_ready),
        .accept          (accept),
        .mem_start       (mem_start),
        .mem_cmd         (mem_cmd),
        .first_rdata     (first_rdata),
        .second_rdata    (second_rdata),
        .rdata_valid     (rdata_valid)
    );

    lane_merge u_merge (
        .offset       (offset),
        .wdata        (wdata),
        .wmask        (wmask),
        .first_rdata  (first_rdata),
        .second_rdata (second_rdata),
        .mem_rdata    (mem_rdata),
        .rdata        (rdata),
        .merged_low   (merged_low),
        .merged_high  (merged_high)
    );

    word_memory u_memory (
        .clk             (clk),
        .rst_n           (rst_n),
        .mem_start       (mem_start),
        .mem_cmd         (mem_cmd),
        .mem_ready       (mem_ready),
        .mem_rdata       (mem_rdata),
        .mem_rdata_valid (mem_rdata_valid)
    );

endmodule

//--- tb_mem_access_ctrl.sv
`include "mac_settings.svh"

module tb_mem_access_ctrl;
    import access_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int LAT        = `MAC_MEM_LATENCY;
    localparam int WORDS      = `MAC_MEM_WORDS;
    localparam int MEM_BYTES  = WORDS * 4;
    localparam int BYTE_W     = $clog2(MEM_BYTES);
    localparam int N_ALIGNED  = 16;
    localparam int N_PARTIAL  = 8;
    localparam int N_RANDOM   = 64;
    // Fill, aligned pairs, partial pairs, known words, random with wrap, busy start
    localparam int TOTAL_ACCESSES =
        WORDS + 2 * N_ALIGNED + 2 * N_PARTIAL + 7 + N_RANDOM + 4 + 4;
    localparam int WATCHDOG_CYCLES = TOTAL_ACCESSES * (4 * LAT + 10);

    logic        clk;
    logic        rst_n;
    logic        req_start;
    access_req_s req;
    logic        cmd_ready;
    logic [31:0] rdata;
    logic        rdata_valid;

    // Byte image of the word memory
    logic [7:0]  model_mem [MEM_BYTES];
    // Expected read data and test names, in issue order
    logic [31:0] expect_q [$];
    string       name_q [$];
    logic [31:0] lfsr_state;
    int          checks;
    int          value_errors;
    int          other_errors;

    mem_access_ctrl uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_start   (req_start),
        .req         (req),
        .cmd_ready   (cmd_ready),
        .rdata       (rdata),
        .rdata_valid (rdata_valid)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per bit
    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    // Initial word contents, every address bit matters
    function automatic logic [31:0] fill_word(input int w);
        logic [31:0] a;
        a = 32'(w);
        return (a * 32'h9e3779b1) ^ {a[15:0], a[31:16]} ^ 32'h5a5a0f0f;
    endfunction

    // Four little-endian bytes from a byte address, wrapping at the top
    function automatic logic [31:0] ref_read(input logic [31:0] addr);
        logic [31:0]       word;
        logic [BYTE_W-1:0] idx;
        idx = addr[BYTE_W-1:0];
        for (int k = 0; k < 4; k++) begin
            word[8*k +: 8] = model_mem[idx];
            idx = idx + BYTE_W'(1);
        end
        return word;
    endfunction

    // Masked bits of each byte take the new data
    task automatic model_write(input logic [31:0] addr, input logic [31:0] data,
                               input logic [31:0] mask);
        logic [BYTE_W-1:0] idx;
        idx = addr[BYTE_W-1:0];
        for (int k = 0; k < 4; k++) begin
            model_mem[idx] = (model_mem[idx] & ~mask[8*k +: 8]) |
                             (data[8*k +: 8] & mask[8*k +: 8]);
            idx = idx + BYTE_W'(1);
        end
    endtask

    task automatic drive_req(input logic write, input logic [31:0] addr,
                             input logic [31:0] data, input logic [31:0] mask);
        req.write    = write;
        req.addr.raw = addr;
        req.wdata    = data;
        req.wmask    = mask;
    endtask

    // Called 2 units after a rising edge
    task automatic wait_idle();
        while (!cmd_ready) begin
            @(posedge clk);
            #2;
        end
    endtask

    // One client access, cycles counts edges from acceptance to completion
    task automatic do_access(input string name, input logic write, input logic [31:0] addr,
                             input logic [31:0] data, input logic [31:0] mask,
                             output int cycles);
        cycles = 0;
        wait_idle();
        drive_req(write, addr, data, mask);
        req_start = 1'b1;
        if (write) begin
            model_write(addr, data, mask);
        end else begin
            expect_q.push_back(ref_read(addr));
            name_q.push_back(name);
        end
        @(posedge clk);
        #2;
        req_start = 1'b0;
        if (write) begin
            do begin
                @(negedge clk);
                cycles++;
            end while (!cmd_ready);
        end else begin
            do begin
                @(negedge clk);
                cycles++;
            end while (!rdata_valid);
        end
        @(posedge clk);
        #2;
    endtask

    // Read data checked in the middle of the valid cycle
    always @(negedge clk) begin : compare
        logic [31:0] expected;
        string       test_name;
        if (rst_n && rdata_valid) begin
            if (expect_q.size() == 0) begin
                other_errors++;
                $display("rdata_valid pulsed with no read outstanding at time %0t", $time);
            end else begin
                expected  = expect_q.pop_front();
                test_name = name_q.pop_front();
                checks++;
                if (rdata !== expected) begin
                    value_errors++;
                    $display("[FAIL] %s: expected %08h, actual %08h",
                             test_name, expected, rdata);
                end
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin : main
        int          cycles;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] mask;
        logic [31:0] op;
        logic [31:0] words [N_ALIGNED];
        logic [31:0] addr_a;
        logic [31:0] addr_b;

        clk          = 1'b0;
        rst_n        = 1'b0;
        req_start    = 1'b0;
        req          = '0;
        lfsr_state   = 32'h00de5224;
        checks       = 0;
        value_errors = 0;
        other_errors = 0;
        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;

        // Idle state straight out of reset
        checks += 2;
        if (cmd_ready !== 1'b1) begin
            value_errors++;
            $display("[FAIL] reset_cmd_ready: expected 1, actual %b", cmd_ready);
        end
        if (rdata_valid !== 1'b0) begin
            value_errors++;
            $display("[FAIL] reset_rdata_valid: expected 0, actual %b", rdata_valid);
        end

        // Known contents everywhere before any read
        for (int w = 0; w < WORDS; w++) begin
            do_access("fill", 1'b1, 32'(w * 4), fill_word(w), '1, cycles);
        end

        // Full-mask aligned writes, then aligned reads with exact latency
        for (int i = 0; i < N_ALIGNED; i++) begin
            take_bits(BYTE_W - 2, addr);
            words[i] = addr << 2;
            take_bits(32, data);
            do_access("aligned_write", 1'b1, words[i], data, '1, cycles);
        end
        for (int i = 0; i < N_ALIGNED; i++) begin
            do_access("aligned_read", 1'b0, words[i], '0, '0, cycles);
            checks++;
            if (cycles != LAT + 1) begin
                value_errors++;
                $display("[FAIL] aligned_read_latency: expected %0d, actual %0d",
                         LAT + 1, cycles);
            end
        end

        // Partial masks on aligned words
        for (int i = 0; i < N_PARTIAL; i++) begin
            take_bits(BYTE_W - 2, addr);
            addr = addr << 2;
            take_bits(32, data);
            take_bits(32, mask);
            if (mask == '1) begin
                mask[0] = 1'b0;
            end
            do_access("partial_write", 1'b1, addr, data, mask, cycles);
            do_access("partial_read", 1'b0, addr, '0, '0, cycles);
        end

        // Bytes be be fe ca, then ef be ad de, at word 100
        do_access("known_write_low", 1'b1, 32'd400, 32'hcafebebe, '1, cycles);
        do_access("known_write_high", 1'b1, 32'd404, 32'hdeadbeef, '1, cycles);
        for (int off = 0; off <= 4; off++) begin
            do_access($sformatf("known_read_off%0d", off), 1'b0, 32'd400 + 32'(off),
                      '0, '0, cycles);
        end

        // Mixed traffic, writes always off the word boundary
        for (int i = 0; i < N_RANDOM; i++) begin
            take_bits(1, op);
            take_bits(BYTE_W, addr);
            if (op[0]) begin
                if (addr[1:0] == 2'd0) begin
                    addr[0] = 1'b1;
                end
                take_bits(32, data);
                take_bits(32, mask);
                do_access("random_write", 1'b1, addr, data, mask, cycles);
            end else begin
                do_access("random_read", 1'b0, addr, '0, '0, cycles);
            end
        end

        // Last word, upper bytes wrap into word 0
        take_bits(32, data);
        take_bits(32, mask);
        do_access("wrap_write", 1'b1, 32'((WORDS - 1) * 4 + 2), data, mask, cycles);
        do_access("wrap_read_off2", 1'b0, 32'((WORDS - 1) * 4 + 2), '0, '0, cycles);
        do_access("wrap_read_off3", 1'b0, 32'((WORDS - 1) * 4 + 3), '0, '0, cycles);
        do_access("wrap_read_word0", 1'b0, 32'd0, '0, '0, cycles);

        // Split write at A, second start toward B while busy
        addr_a = 32'd801;
        addr_b = 32'd1202;
        wait_idle();
        take_bits(32, data);
        drive_req(1'b1, addr_a, data, '1);
        req_start = 1'b1;
        model_write(addr_a, data, '1);
        @(posedge clk);
        #2;
        take_bits(32, data);
        drive_req(1'b1, addr_b, data, '1);
        if (cmd_ready) begin
            other_errors++;
            $display("cmd_ready was high right after acceptance, busy start not exercised");
        end
        @(posedge clk);
        #2;
        req_start = 1'b0;
        wait_idle();
        do_access("busy_start_read_b", 1'b0, addr_b, '0, '0, cycles);
        do_access("busy_start_read_a", 1'b0, addr_a, '0, '0, cycles);

        if (expect_q.size() != 0) begin
            other_errors++;
            $display("%0d reads never returned data", expect_q.size());
        end
        $display("Checks: %0d, value errors: %0d, other errors: %0d",
                 checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- project.f
+incdir+.
access_pkg.sv
mem_pkg.sv
access_decode.sv
access_sequencer.sv
lane_merge.sv
word_memory.sv
mem_access_ctrl.sv
tb_mem_access_ctrl.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_mem_access_ctrl
RTL_TOP   ?= mem_access_ctrl
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "RESULT: PASS" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
